//--- all.f
verilog/permPkg.sv
verilog/permutationGenerator.sv
verilog/termPipeline.sv
verilog/resultStage.sv
verilog/fullPermutationPipeline.sv
bench/benchClock.sv
bench/pipelineChecker.sv
bench/pipelineBind_sva.sv
bench/tbTop.sv

//--- bench/benchClock.sv
`timescale 1ns/1ps

module benchClock #(
    parameter int PERIOD_NS = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1; // released between active edges.
    end

endmodule

//--- bench/pipelineBind_sva.sv
`timescale 1ns/1ps

module pipelineBindSva import permPkg::*; (
    input logic clk,
    input logic arstN,
    input logic writeBot,
    input logic readyForInputBot,
    input logic grabResults,
    input logic resultsAvailable,
    input pcoeffResult pcoeff
);

    resetValues: assert property (@(posedge clk)
        $rose(arstN) |-> readyForInputBot && !resultsAvailable)
        else $error("pipeline not empty and ready after reset");

    writeOnlyWhenReady: assert property (@(posedge clk) disable iff (!arstN)
        writeBot |-> readyForInputBot)
        else $error("writeBot issued while readyForInputBot is low");

    // output register holds until the caller grabs.
    holdUntilGrab: assert property (@(posedge clk) disable iff (!arstN)
        resultsAvailable && !grabResults |=> resultsAvailable && $stable(pcoeff))
        else $error("result dropped or changed before grab");

endmodule

bind fullPermutationPipeline pipelineBindSva sva (
    .clk(clk),
    .arstN(arstN),
    .writeBot(writeBot),
    .readyForInputBot(readyForInputBot),
    .grabResults(grabResults),
    .resultsAvailable(resultsAvailable),
    .pcoeff(pcoeff)
);

//--- bench/pipelineChecker.sv
`timescale 1ns/1ps

module pipelineChecker import permPkg::*; #(
    parameter int EXPECTED_RESULTS = 1
) (
    input  logic clk,
    input  logic arstN,
    input  logic [FUNC_BITS-1:0] top,
    input  logic [FUNC_BITS-1:0] bot,
    input  logic writeBot,
    input  logic readyForInputBot,
    input  logic grabResults,
    input  logic resultsAvailable,
    input  pcoeffResult pcoeff,
    input  logic testsDone,
    output int valueErrors,
    output int otherErrors,
    output int resultsChecked
);

    localparam int STALL_LIMIT = 6; // an unstalled batch keeps ready low for 6 cycles.

    pcoeffResult expected[$];
    pcoeffResult want;
    pcoeffResult heldValue;
    logic holdPending;
    logic inReset;
    logic stallSeen;
    logic finalDone;
    int readyLowRun;

    // moves variable a to 4, b to 5 and c to 6.
    function automatic logic [FUNC_BITS-1:0] mapVars(
        input logic [FUNC_BITS-1:0] f,
        input int a,
        input int b,
        input int c
    );
        logic [FUNC_BITS-1:0] r;
        logic [6:0] s;
        logic [6:0] d;
        r = '0;
        for (int j = 0; j < FUNC_BITS; j++) begin
            s = 7'(j);
            d = s;
            d[4] = s[a];
            d[5] = s[b];
            d[6] = s[c];
            r[d] = f[j];
        end
        return r;
    endfunction

    function automatic pcoeffResult expectedFor(
        input logic [FUNC_BITS-1:0] t,
        input logic [FUNC_BITS-1:0] b
    );
        pcoeffResult e;
        logic [FUNC_BITS-1:0] p;
        e = '0;
        for (int x = 4; x < 7; x++) begin
            for (int y = 4; y < 7; y++) begin
                for (int z = 4; z < 7; z++) begin
                    if (x != y && y != z && x != z) begin
                        p = mapVars(b, x, y, z);
                        if ((p & ~t) == '0) begin
                            e.count = e.count + COUNT_BITS'(1);
                            e.sum = e.sum + SUM_BITS'($countones(t & ~p));
                        end
                    end
                end
            end
        end
        return e;
    endfunction

    always @(posedge clk) begin
        if (!arstN) begin
            inReset = 1'b1;
            holdPending = 1'b0;
            stallSeen = 1'b0;
            finalDone = 1'b0;
            readyLowRun = 0;
            valueErrors = 0;
            otherErrors = 0;
            resultsChecked = 0;
        end else begin
            if (inReset && (resultsAvailable || !readyForInputBot)) begin
                $display("Wrong state after reset at %0t: resultsAvailable=%b ready=%b",
                         $time, resultsAvailable, readyForInputBot);
                otherErrors++;
            end
            inReset = 1'b0;
            if (holdPending && !resultsAvailable) begin
                $display("Result withdrawn before it was grabbed at %0t", $time);
                otherErrors++;
            end else if (holdPending && pcoeff !== heldValue) begin
                $display("CHECK FAILED at %0t: held pcoeff changed from %h to %h",
                         $time, heldValue, pcoeff);
                valueErrors++;
            end
            if (writeBot && readyForInputBot) begin
                expected.push_back(expectedFor(top, bot));
            end else if (writeBot) begin
                $display("Bot written while the pipeline was not ready at %0t", $time);
                otherErrors++;
            end
            if (resultsAvailable && grabResults) begin
                if (expected.size() == 0) begin
                    $display("Result grabbed at %0t with no bot outstanding", $time);
                    otherErrors++;
                end else begin
                    want = expected.pop_front();
                    resultsChecked++;
                    if (pcoeff !== want) begin
                        $display("CHECK FAILED at %0t: result %0d sum %0d count %0d, want %0d %0d",
                                 $time, resultsChecked, pcoeff.sum, pcoeff.count,
                                 want.sum, want.count);
                        valueErrors++;
                    end
                end
            end
            holdPending = resultsAvailable && !grabResults;
            heldValue = pcoeff;
            readyLowRun = readyForInputBot ? 0 : readyLowRun + 1;
            if (readyLowRun > STALL_LIMIT) begin
                stallSeen = 1'b1;
            end
            if (testsDone && !finalDone) begin
                finalDone = 1'b1;
                if (expected.size() != 0 || resultsChecked != EXPECTED_RESULTS) begin
                    $display("Lost results: %0d checked of %0d, %0d bots never answered",
                             resultsChecked, EXPECTED_RESULTS, expected.size());
                    otherErrors++;
                end
                if (!stallSeen) begin
                    $display("Back-pressure never stalled the input");
                    otherErrors++;
                end
            end
        end
    end

endmodule

//--- bench/tbTop.sv
`timescale 1ns/1ps

module tbTop import permPkg::*; ();

    localparam int LATENCY = 5;
    localparam int HAND_ROWS = 6;
    localparam int NUM_ROWS = HAND_ROWS + 8;
    localparam int BURST_BOTS = 5;
    localparam int DRAIN_DELAY = 60;
    localparam logic [FUNC_BITS-1:0] ALL_ONES = '1;
    localparam logic [FUNC_BITS-1:0] PARITY7 = 128'h9669_6996_6996_9669_6996_9669_9669_6996;
    localparam logic [FUNC_BITS-1:0] MAJ456 = 128'hFFFF_FFFF_FFFF_0000_FFFF_0000_0000_0000;

    typedef struct packed {
        logic [FUNC_BITS-1:0] top;
        logic [FUNC_BITS-1:0] bot;
        logic [7:0] grabDelay;
    } stimRow;

    logic clk;
    logic arstN;
    logic [FUNC_BITS-1:0] top;
    logic [FUNC_BITS-1:0] bot;
    logic writeBot;
    logic readyForInputBot;
    logic grabResults;
    logic resultsAvailable;
    pcoeffResult pcoeff;
    logic testsDone;
    int valueErrors;
    int otherErrors;
    int resultsChecked;

    stimRow rows [NUM_ROWS];
    logic [FUNC_BITS-1:0] burstBots [BURST_BOTS];
    logic [FUNC_BITS-1:0] burstTop;
    logic [31:0] lfsrState;
    int limitCycles;

    benchClock clkGen (.clk(clk), .arstN(arstN));

    fullPermutationPipeline #(.RESULT_LATENCY(LATENCY)) dut (
        .clk(clk),
        .arstN(arstN),
        .top(top),
        .bot(bot),
        .writeBot(writeBot),
        .readyForInputBot(readyForInputBot),
        .grabResults(grabResults),
        .resultsAvailable(resultsAvailable),
        .pcoeff(pcoeff)
    );

    pipelineChecker #(.EXPECTED_RESULTS(NUM_ROWS + BURST_BOTS)) resultCheck (
        .clk(clk),
        .arstN(arstN),
        .top(top),
        .bot(bot),
        .writeBot(writeBot),
        .readyForInputBot(readyForInputBot),
        .grabResults(grabResults),
        .resultsAvailable(resultsAvailable),
        .pcoeff(pcoeff),
        .testsDone(testsDone),
        .valueErrors(valueErrors),
        .otherErrors(otherErrors),
        .resultsChecked(resultsChecked)
    );

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [FUNC_BITS-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v[i] = lfsrState[0];
        end
    endtask

    function automatic stimRow makeRow(
        input logic [FUNC_BITS-1:0] t,
        input logic [FUNC_BITS-1:0] b,
        input int delay
    );
        stimRow row;
        row.top = t;
        row.bot = b;
        row.grabDelay = 8'(delay);
        return row;
    endfunction

    task automatic buildTable();
        logic [FUNC_BITS-1:0] r1;
        logic [FUNC_BITS-1:0] r2;
        logic [FUNC_BITS-1:0] r3;
        logic [FUNC_BITS-1:0] d;
        rows[0] = makeRow(ALL_ONES, '0, 0);
        rows[1] = makeRow(128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210, '0, 3);
        rows[2] = makeRow(128'hDEAD_BEEF_0F0F_F0F0_1357_9BDF_2468_ACE0,
                          128'hDEAD_BEEF_0F0F_F0F0_1357_9BDF_2468_ACE0, 1);
        rows[3] = makeRow(~128'h1, 128'h1, 2); // bit 0 is fixed by every permutation.
        rows[4] = makeRow(PARITY7, PARITY7, 4);
        rows[5] = makeRow(ALL_ONES, MAJ456, 7);
        for (int r = HAND_ROWS; r < NUM_ROWS; r++) begin
            takeBits(FUNC_BITS, r1);
            takeBits(FUNC_BITS, r2);
            takeBits(FUNC_BITS, r3);
            takeBits(4, d);
            if (r % 2 == 0) begin
                rows[r] = makeRow(r1 | r2, r1 & r2, int'(d[3:0]));
            end else begin
                rows[r] = makeRow(r1 | r2, r3 & {4{32'h0000_0011}}, int'(d[3:0]));
            end
        end
        takeBits(FUNC_BITS, r1);
        takeBits(FUNC_BITS, r2);
        burstTop = r1 | r2;
        for (int b = 0; b < BURST_BOTS; b++) begin
            takeBits(FUNC_BITS, r3);
            burstBots[b] = r3 & r1;
        end
        limitCycles = BURST_BOTS * (100 + DRAIN_DELAY);
        for (int r = 0; r < NUM_ROWS; r++) begin
            limitCycles += 100 + int'(rows[r].grabDelay);
        end
    endtask

    task automatic writeOne(input logic [FUNC_BITS-1:0] b);
        while (!readyForInputBot) @(negedge clk);
        bot = b;
        writeBot = 1'b1;
        @(negedge clk);
        writeBot = 1'b0;
    endtask

    task automatic grabAfter(input int delay);
        while (!resultsAvailable) @(negedge clk);
        repeat (delay) @(negedge clk);
        grabResults = 1'b1;
        @(negedge clk);
        grabResults = 1'b0;
    endtask

    initial begin
        top = '0;
        bot = '0;
        writeBot = 1'b0;
        grabResults = 1'b0;
        testsDone = 1'b0;
        lfsrState = 32'h544;
        buildTable();
        fork
            begin
                repeat (limitCycles) @(posedge clk);
                $display("Timeout: pipeline still busy after %0d cycles", limitCycles);
                $display("Test failures found");
                $finish;
            end
        join_none
        wait (arstN);
        @(negedge clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            top = rows[r].top;
            writeOne(rows[r].bot);
            grabAfter(int'(rows[r].grabDelay));
        end
        top = burstTop; // held for the whole burst.
        fork
            begin
                for (int b = 0; b < BURST_BOTS; b++) begin
                    writeOne(burstBots[b]);
                end
            end
            begin
                repeat (DRAIN_DELAY) @(negedge clk);
                for (int b = 0; b < BURST_BOTS; b++) begin
                    grabAfter(0);
                end
            end
        join
        repeat (4) @(negedge clk);
        testsDone = 1'b1;
        @(negedge clk);
        $display("errors: %0d wrong values, %0d other failures, %0d results checked",
                 valueErrors, otherErrors, resultsChecked);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator; exits non-zero unless the run passes.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbTop -f all.f -o simv

out=$(./obj_dir/simv)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "All tests passed!"

//--- verilog/fullPermutationPipeline.sv
`timescale 1ns/1ps

module fullPermutationPipeline import permPkg::*; #(
    parameter int RESULT_LATENCY = 5
) (
    input  logic clk,
    input  logic arstN,

    input  logic [FUNC_BITS-1:0] top,

    input  logic [FUNC_BITS-1:0] bot,
    input  logic writeBot,
    output logic readyForInputBot,

    input  logic grabResults,
    output logic resultsAvailable,
    output pcoeffResult pcoeff
);

    logic [FUNC_BITS-1:0] permutedBot;
    logic permutedBotValid;
    logic batchDone;
    logic slowDownInput;
    logic grabNewResult;
    logic pipelineResultAvailable;
    pcoeffResult pipelineResult;

    permutationGenerator permGen (
        .clk(clk),
        .arstN(arstN),
        .inputBot(bot),
        .writeInputBot(writeBot),
        .hasSpaceForNextBot(readyForInputBot),
        .slowDown(slowDownInput),
        .outputBot(permutedBot),
        .outputBotValid(permutedBotValid),
        .botSeriesFinished(batchDone)
    );

    termPipeline #(.RESULT_LATENCY(RESULT_LATENCY)) computePipe (
        .clk(clk),
        .arstN(arstN),
        .top(top),
        .bot(permutedBot),
        .isBotValid(permutedBotValid),
        .batchDone(batchDone),
        .slowDownInput(slowDownInput),
        .grabResults(grabNewResult),
        .resultsAvailable(pipelineResultAvailable),
        .result(pipelineResult)
    );

    // both sides must use the same latency.
    resultStage #(.RESULT_LATENCY(RESULT_LATENCY)) outStage (
        .clk(clk),
        .arstN(arstN),
        .pipelineResultAvailable(pipelineResultAvailable),
        .pipelineResult(pipelineResult),
        .grabNewResult(grabNewResult),
        .grabResults(grabResults),
        .resultsAvailable(resultsAvailable),
        .data(pcoeff)
    );

endmodule

//--- verilog/permPkg.sv
package permPkg;

    localparam int FUNC_BITS = 128;
    localparam int SUM_BITS = 48;
    localparam int COUNT_BITS = 13;
    localparam int PERM_COUNT = 6;

    typedef struct packed {
        logic [SUM_BITS-1:0] sum;
        logic [COUNT_BITS-1:0] count;
    } pcoeffResult;

    typedef enum logic [0:0] {
        stIdle,
        stEmitting
    } genState;

    // reorders variables 4, 5 and 6, index 0 is the identity.
    function automatic logic [FUNC_BITS-1:0] permuteVars(
        input logic [FUNC_BITS-1:0] f,
        input logic [2:0] permIdx
    );
        logic [2:0][2:0] img;
        logic [6:0] dst;
        logic [6:0] src;
        logic [FUNC_BITS-1:0] res;
        case (permIdx) // img[k] is the image of variable 4+k.
            3'd1: img = {3'd5, 3'd6, 3'd4};
            3'd2: img = {3'd6, 3'd4, 3'd5};
            3'd3: img = {3'd4, 3'd6, 3'd5};
            3'd4: img = {3'd5, 3'd4, 3'd6};
            3'd5: img = {3'd4, 3'd5, 3'd6};
            default: img = {3'd6, 3'd5, 3'd4};
        endcase
        for (int i = 0; i < FUNC_BITS; i++) begin
            dst = 7'(i);
            src = dst;
            for (int k = 0; k < 3; k++) begin
                src[img[k]] = dst[4 + k];
            end
            res[i] = f[src];
        end
        return res;
    endfunction

endpackage

//--- verilog/permutationGenerator.sv
`timescale 1ns/1ps

module permutationGenerator import permPkg::*; (
    input  logic clk,
    input  logic arstN,

    input  logic [FUNC_BITS-1:0] inputBot,
    input  logic writeInputBot,
    output logic hasSpaceForNextBot,

    input  logic slowDown,
    output logic [FUNC_BITS-1:0] outputBot,
    output logic outputBotValid,
    output logic botSeriesFinished
);

    localparam logic [2:0] LAST_PERM = 3'(PERM_COUNT - 1);

    genState state;
    logic [FUNC_BITS-1:0] storedBot;
    logic [2:0] permIdx;
    logic acceptBot;
    logic emitNow;
    logic isLastPerm;

    assign hasSpaceForNextBot = state == stIdle;
    assign acceptBot = writeInputBot && hasSpaceForNextBot;
    assign emitNow = (state == stEmitting) && !slowDown; // hold while pipeline is full.
    assign isLastPerm = permIdx == LAST_PERM;

    assign outputBot = permuteVars(storedBot, permIdx);
    assign outputBotValid = emitNow;
    assign botSeriesFinished = emitNow && isLastPerm;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            permIdx <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (acceptBot) begin
                        state <= stEmitting;
                        permIdx <= '0;
                    end
                end
                stEmitting: begin
                    if (emitNow) begin
                        if (isLastPerm) begin
                            state <= stIdle; // ready again next cycle.
                            permIdx <= '0;
                        end else begin
                            permIdx <= permIdx + 3'd1;
                        end
                    end
                end
                default: begin
                    state <= stIdle;
                    permIdx <= '0;
                end
            endcase
        end
    end

    // bot is only captured when idle.
    always_ff @(posedge clk) begin
        if (acceptBot) begin
            storedBot <= inputBot;
        end
    end

endmodule

//--- verilog/resultStage.sv
`timescale 1ns/1ps

module resultStage import permPkg::*; #(
    parameter int RESULT_LATENCY = 5
) (
    input  logic clk,
    input  logic arstN,

    input  logic pipelineResultAvailable,
    input  pcoeffResult pipelineResult,
    output logic grabNewResult,

    input  logic grabResults,
    output logic resultsAvailable,
    output pcoeffResult data
);

    localparam int SPACING = RESULT_LATENCY + 2;
    localparam int SPACE_BITS = $clog2(SPACING + 1);

    logic [SPACE_BITS-1:0] cyclesSinceGrab;
    logic [RESULT_LATENCY-1:0] grabDelay;
    logic spacingDone;
    logic grabInFlight;
    logic loadResult;
    logic hasData;

    assign spacingDone = cyclesSinceGrab == SPACE_BITS'(SPACING);
    assign grabInFlight = |grabDelay;
    assign loadResult = grabDelay[RESULT_LATENCY-1]; // pipeline result valid now.
    assign grabNewResult = !hasData && pipelineResultAvailable && !grabInFlight && spacingDone;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cyclesSinceGrab <= SPACE_BITS'(SPACING);
            grabDelay <= '0;
            hasData <= 1'b0;
        end else begin
            if (grabNewResult) begin
                cyclesSinceGrab <= '0;
            end else if (!spacingDone) begin
                cyclesSinceGrab <= cyclesSinceGrab + 1'b1;
            end
            grabDelay[0] <= grabNewResult;
            for (int k = 1; k < RESULT_LATENCY; k++) begin
                grabDelay[k] <= grabDelay[k-1];
            end
            if (loadResult) begin
                hasData <= 1'b1;
            end else if (grabResults) begin
                hasData <= 1'b0; // caller took it.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadResult) begin
            data <= pipelineResult;
        end
    end

    assign resultsAvailable = hasData;

endmodule

//--- verilog/termPipeline.sv
`timescale 1ns/1ps

module termPipeline import permPkg::*; #(
    parameter int RESULT_LATENCY = 5
) (
    input  logic clk,
    input  logic arstN,

    input  logic [FUNC_BITS-1:0] top,
    input  logic [FUNC_BITS-1:0] bot,
    input  logic isBotValid,
    input  logic batchDone,
    output logic slowDownInput,

    input  logic grabResults,
    output logic resultsAvailable,
    output pcoeffResult result
);

    localparam int ONES_BITS = $clog2(FUNC_BITS + 1);

    // stage 1 registers.
    logic s1Valid;
    logic s1Last;
    logic s1Subset;
    logic [FUNC_BITS-1:0] s1Rest;

    // stage 2 registers.
    logic s2Last;
    logic s2Hit;
    logic [ONES_BITS-1:0] s2Ones;

    logic [ONES_BITS-1:0] onesCount;
    logic [SUM_BITS-1:0] accSum;
    logic [COUNT_BITS-1:0] accCount;
    logic [SUM_BITS-1:0] sumNext;
    logic [COUNT_BITS-1:0] countNext;

    logic bufFull;
    pcoeffResult resultBuf;
    pcoeffResult [RESULT_LATENCY-1:0] resultChain;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Valid <= 1'b0;
            s1Last <= 1'b0;
            s2Last <= 1'b0;
        end else begin
            s1Valid <= isBotValid;
            s1Last <= isBotValid && batchDone;
            s2Last <= s1Valid && s1Last;
        end
    end

    always_ff @(posedge clk) begin
        s1Subset <= (bot & ~top) == '0;
        s1Rest <= top & ~bot;
    end

    always_comb begin
        onesCount = '0;
        for (int i = 0; i < FUNC_BITS; i++) begin
            onesCount = onesCount + ONES_BITS'(s1Rest[i]);
        end
    end

    // invalid or non-subset terms add nothing.
    always_ff @(posedge clk) begin
        s2Hit <= s1Valid && s1Subset;
        s2Ones <= (s1Valid && s1Subset) ? onesCount : '0;
    end

    assign sumNext = accSum + SUM_BITS'(s2Ones);
    assign countNext = accCount + COUNT_BITS'(s2Hit);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            accSum <= '0;
            accCount <= '0;
            bufFull <= 1'b0;
        end else if (s2Last) begin
            accSum <= '0; // next batch starts from zero.
            accCount <= '0;
            bufFull <= 1'b1;
        end else begin
            accSum <= sumNext;
            accCount <= countNext;
            if (grabResults) begin
                bufFull <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s2Last) begin
            resultBuf.sum <= sumNext;
            resultBuf.count <= countNext;
        end
    end

    // fixed-latency fetch path.
    always_ff @(posedge clk) begin
        if (grabResults) begin
            resultChain[0] <= resultBuf;
        end
        for (int k = 1; k < RESULT_LATENCY; k++) begin
            resultChain[k] <= resultChain[k-1];
        end
    end

    assign slowDownInput = bufFull;
    assign resultsAvailable = bufFull;
    assign result = resultChain[RESULT_LATENCY-1];

endmodule
